/* Bender.yml */
package:
  name: atom_system

sources:
  - include_dirs:
      - src
    files:
      - src/atom_bus_pkg.sv
      - src/atom_io_pkg.sv
      - src/cpu_bus_if.sv
      - src/atom_clock_reset.sv
      - src/atom_memory_map.sv
      - src/atom_pia.sv
      - src/atom_read_mux.sv
      - src/atom_system.sv
  - target: test
    files:
      - verification/atom_system_checker.sv
      - verification/atom_system_tb.sv

/* flist.f */
+incdir+src
src/atom_bus_pkg.sv
src/atom_io_pkg.sv
src/cpu_bus_if.sv
src/atom_clock_reset.sv
src/atom_memory_map.sv
src/atom_pia.sv
src/atom_read_mux.sv
src/atom_system.sv
verification/atom_system_checker.sv
verification/atom_system_tb.sv

/* src/atom_bus_pkg.sv */
// ====================
// CPU bus and memory map types
// Region select bit positions
// ====================

`include "atom_settings.svh"

package atom_bus_pkg;

   // CPU address and data
   typedef logic [`ATOM_ADDR_BITS-1:0] addr_t;
   typedef logic [`ATOM_DATA_BITS-1:0] byte_t;

   // External SRAM address
   typedef logic [`ATOM_RAM_ADDR_BITS-1:0] ram_addr_t;

   // One-hot region select, all zero means plain RAM
   typedef logic [7:0] region_t;

   // Bank number held in the low bits of the ROM latch
   typedef logic [2:0] rom_bank_t;

   // ====================
   // Region bit positions
   // ====================
   localparam int REG_ROM   = 0;  // C000-FFFF
   localparam int REG_PIA   = 1;  // B000-B00F
   localparam int REG_PL8   = 2;  // B400-B40F, reads zero
   localparam int REG_VIA   = 3;  // B800-B80F
   localparam int REG_SPI   = 4;  // BC00-BC0F
   localparam int REG_SID   = 5;  // BD00-BDFF
   localparam int REG_VID   = 6;  // 8000-8FFF
   localparam int REG_LATCH = 7;  // BFFF only

endpackage

/* src/atom_clock_reset.sv */
// ====================
// CPU clock enable divider, 1 to 8MHz
// Write gate on the falling edge
// Power-up reset stretcher
// ====================

`timescale 1ns/100ps
`include "atom_settings.svh"

module atom_clock_reset
   (
   input  logic                clk25,
   input  logic                reset,
   input  atom_io_pkg::speed_t speed,
   output logic                cpu_clken,
   output logic                wegate_b,
   output logic                sys_reset
   );
   import atom_io_pkg::*;

   localparam int DIV_BITS = $clog2(`ATOM_CLKDIV_PERIOD);

   logic [DIV_BITS-1:0]         clkdiv;
   logic                        in_window;
   logic                        clken_next;
   logic                        cpu_clken_d;
   logic [`ATOM_PWRUP_BITS-1:0] pwrup_count;
   logic                        pwrup_done;

   // ====================
   // Divider
   // ====================
   // Pulses only in the first 16 counts of the frame
   assign in_window = (clkdiv < DIV_BITS'(16));

   always_comb
   begin
      case (speed)
         SPEED_1MHZ: clken_next = in_window && (clkdiv[3:0] == 4'd0);
         SPEED_2MHZ: clken_next = in_window && (clkdiv[2:0] == 3'd0);
         SPEED_4MHZ: clken_next = in_window && (clkdiv[1:0] == 2'd0);
         default:    clken_next = in_window && !clkdiv[0];
      endcase
   end

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         clkdiv      <= '0;
         cpu_clken   <= 1'b0;
         cpu_clken_d <= 1'b0;
      end
      else
      begin
         // Wrap at end of frame
         if (clkdiv == DIV_BITS'(`ATOM_CLKDIV_PERIOD - 1))
            clkdiv <= '0;
         else
            clkdiv <= clkdiv + 1'b1;
         cpu_clken   <= clken_next;
         cpu_clken_d <= cpu_clken;
      end
   end

   // Opposite edge, keeps the gate centred in the 8MHz window
   always_ff @(negedge clk25 or posedge reset)
   begin
      if (reset)
         wegate_b <= 1'b1;
      else
         wegate_b <= !cpu_clken_d;
   end

   // ====================
   // Power-up reset
   // ====================
   assign pwrup_done = &pwrup_count;

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pwrup_count <= '0;
         sys_reset   <= 1'b1;
      end
      else if (cpu_clken)
      begin
         if (!pwrup_done)
            pwrup_count <= pwrup_count + 1'b1;
         // Released one pulse after the count fills
         sys_reset <= !pwrup_done;
      end
   end

endmodule

/* src/atom_io_pkg.sv */
// ====================
// PIA, keyboard and clock speed types
// Register and speed codes
// ====================

`include "atom_settings.svh"

package atom_io_pkg;

   // Turbo speed select
   typedef logic [1:0] speed_t;

   // 8255 register index, from A1:A0
   typedef logic [1:0] pia_reg_t;

   // Keyboard column read on port B
   typedef logic [5:0] key_col_t;

   // Writable low nibble of port C
   typedef logic [3:0] pia_pc_low_t;

   // ====================
   // Turbo codes
   // ====================
   localparam speed_t SPEED_1MHZ = 2'd0;
   localparam speed_t SPEED_2MHZ = 2'd1;
   localparam speed_t SPEED_4MHZ = 2'd2;
   localparam speed_t SPEED_8MHZ = 2'd3;

   // PIA register map
   localparam pia_reg_t PIA_PORT_A = 2'd0;
   localparam pia_reg_t PIA_PORT_B = 2'd1;
   localparam pia_reg_t PIA_PORT_C = 2'd2;
   localparam pia_reg_t PIA_CTRL   = 2'd3;

endpackage

/* src/atom_memory_map.sv */
// ====================
// CPU bus capture and address decode
// ROM bank latch, lock snoop
// External SRAM address and strobes
// ====================

`timescale 1ns/100ps
`include "atom_settings.svh"

module atom_memory_map
   (
   input  logic                   clk25,
   input  logic                   sys_reset,
   input  atom_bus_pkg::addr_t    cpu_address,
   input  atom_bus_pkg::byte_t    cpu_wdata,
   input  logic                   cpu_we,
   input  logic                   wegate_b,
   cpu_bus_if.source              bus,
   output atom_bus_pkg::byte_t    rom_latch,
   output atom_bus_pkg::ram_addr_t ram_addr,
   output logic                   ram_we_b,
   output logic                   ram_oe_b,
   output logic                   lock
   );
   import atom_bus_pkg::*;

   region_t   region_d;
   logic      a000_sel;
   logic      bus_write;
   rom_bank_t bank;

   // ====================
   // Bus capture
   // ====================
   // Core outputs are only valid alongside cpu_clken
   always_ff @(posedge clk25 or posedge sys_reset)
   begin
      if (sys_reset)
      begin
         bus.address <= '0;
         bus.rnw     <= 1'b1;
      end
      else if (bus.cpu_clken)
      begin
         bus.address <= cpu_address;
         bus.rnw     <= !cpu_we;
      end
   end

   // Write data is payload only
   always_ff @(posedge clk25)
   begin
      if (bus.cpu_clken)
         bus.wdata <= cpu_wdata;
   end

   // ====================
   // Address decode
   // ====================
   always_comb
   begin
      region_d            = '0;
      region_d[REG_ROM]   = (bus.address[15:14] == 2'b11);
      region_d[REG_PIA]   = (bus.address[15:4] == 12'hB00);
      region_d[REG_PL8]   = (bus.address[15:4] == 12'hB40);
      region_d[REG_VIA]   = (bus.address[15:4] == 12'hB80);
      region_d[REG_SPI]   = (bus.address[15:4] == 12'hBC0);
      region_d[REG_SID]   = (bus.address[15:8] == 8'hBD);
      region_d[REG_VID]   = (bus.address[15:12] == 4'h8);
      region_d[REG_LATCH] = (bus.address == 16'hBFFF);
   end

   assign bus.region = region_d;

   // Banked ROM window, mapped into SRAM
   assign a000_sel  = (bus.address[15:12] == 4'hA);
   assign bus_write = bus.cpu_clken && !bus.rnw;

   // ====================
   // ROM latch and lock
   // ====================
   always_ff @(posedge clk25 or posedge sys_reset)
   begin
      if (sys_reset)
      begin
         rom_latch <= '0;
         lock      <= 1'b0;
      end
      else if (bus_write)
      begin
         if (region_d[REG_LATCH])
            rom_latch <= bus.wdata;
         // Snoop of the OS lock flag
         if (bus.address == `ATOM_LOCK_ADDR)
            lock <= bus.wdata[5];
      end
   end

   // ====================
   // External SRAM
   // ====================
   assign bank     = rom_latch[2:0];
   assign ram_addr = a000_sel ? {3'b010, bank, bus.address[11:0]} : {2'b00, bus.address};
   assign ram_oe_b = !bus.rnw;

   // ROM area is write protected
   assign ram_we_b = bus.rnw || wegate_b || region_d[REG_ROM];

endmodule

/* src/atom_pia.sv */
// ====================
// 8255 PIA model, fixed port directions
// Cassette tone, cassette out, sound
// ====================

`timescale 1ns/100ps
`include "atom_settings.svh"

module atom_pia
   (
   input  logic                     clk25,
   input  logic                     sys_reset,
   cpu_bus_if.sink                  bus,
   input  atom_io_pkg::key_col_t    key_col,
   input  logic                     shift_n,
   input  logic                     ctrl_n,
   input  logic                     rept_n,
   input  logic                     fs_n,
   input  logic                     cas_in,
   input  logic                     sid_audio,
   output atom_bus_pkg::byte_t      pia_dout,
   output atom_bus_pkg::byte_t      port_a,
   output atom_io_pkg::pia_pc_low_t pc_low,
   output logic                     cas_out,
   output logic                     sound
   );
   import atom_bus_pkg::*;
   import atom_io_pkg::*;

   localparam int CAS_BITS = $clog2(`ATOM_CAS_HALF_PERIOD);

   pia_reg_t            reg_sel;
   byte_t               port_b;
   byte_t               port_c;
   logic                cas_tone;
   logic [CAS_BITS-1:0] cas_div;

   assign reg_sel = bus.address[1:0];

   // ====================
   // Register writes
   // ====================
   always_ff @(posedge clk25 or posedge sys_reset)
   begin
      if (sys_reset)
      begin
         port_a <= '0;
         pc_low <= '0;
      end
      else if (bus.cpu_clken && !bus.rnw && bus.region[REG_PIA])
      begin
         case (reg_sel)
            PIA_PORT_A: port_a <= bus.wdata;
            PIA_PORT_C: pc_low <= bus.wdata[3:0];
            // Bit set/reset, mode words ignored
            PIA_CTRL:
               if (!bus.wdata[7])
                  pc_low[bus.wdata[2:1]] <= bus.wdata[0];
            default: ;
         endcase
      end
   end

   // Inputs as seen on the read side
   assign port_b = {shift_n, ctrl_n, key_col};
   assign port_c = {fs_n, rept_n, cas_in, cas_tone, pc_low};

   always_comb
   begin
      case (reg_sel)
         PIA_PORT_A: pia_dout = port_a;
         PIA_PORT_B: pia_dout = port_b;
         PIA_PORT_C: pia_dout = port_c;
         default:    pia_dout = '0;
      endcase
   end

   // ====================
   // Cassette tone
   // ====================
   always_ff @(posedge clk25 or posedge sys_reset)
   begin
      if (sys_reset)
      begin
         cas_div  <= '0;
         cas_tone <= 1'b0;
      end
      else if (bus.cpu_clken)
      begin
         if (cas_div == CAS_BITS'(`ATOM_CAS_HALF_PERIOD - 1))
         begin
            cas_div  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_div <= cas_div + 1'b1;
      end
   end

   // pc0 enables output, pc1 gates in the tone
   assign cas_out = pc_low[0] && !(pc_low[1] && !cas_tone);

   // Speaker mixed with SID
   assign sound = pc_low[2] ^ sid_audio;

endmodule

/* src/atom_read_mux.sv */
// ====================
// CPU read data multiplexer
// ====================

`timescale 1ns/100ps

module atom_read_mux
   (
   cpu_bus_if.sink             bus,
   input  atom_bus_pkg::byte_t pia_dout,
   input  atom_bus_pkg::byte_t rom_latch,
   input  atom_bus_pkg::byte_t vid_dout,
   input  atom_bus_pkg::byte_t via_dout,
   input  atom_bus_pkg::byte_t spi_dout,
   input  atom_bus_pkg::byte_t sid_dout,
   input  atom_bus_pkg::byte_t ram_din,
   output atom_bus_pkg::byte_t cpu_din
   );
   import atom_bus_pkg::*;

   // ====================
   // Priority select
   // ====================
   // Regions are disjoint, order only matters for X and glitches
   always_comb
   begin
      if (bus.region[REG_VID])
         cpu_din = vid_dout;
      else if (bus.region[REG_PIA])
         cpu_din = pia_dout;
      else if (bus.region[REG_PL8])
         // Empty slot reads back zero
         cpu_din = '0;
      else if (bus.region[REG_SPI])
         cpu_din = spi_dout;
      else if (bus.region[REG_VIA])
         cpu_din = via_dout;
      else if (bus.region[REG_SID])
         cpu_din = sid_dout;
      else if (bus.region[REG_LATCH])
         cpu_din = rom_latch;
      else
         // RAM, banked ROM and main ROM all live in SRAM
         cpu_din = ram_din;
   end

endmodule

/* src/atom_settings.svh */
// ====================
// Atom glue settings
// Bus widths, memory map constants,
// divider and cassette tone counts
// ====================

`ifndef ATOM_SETTINGS_SVH
`define ATOM_SETTINGS_SVH

// CPU bus widths
`define ATOM_ADDR_BITS 16
`define ATOM_DATA_BITS 8

// External SRAM, 256K x 8
`define ATOM_RAM_ADDR_BITS 18

// clk25 cycles per divider frame, 1us at 25MHz
`define ATOM_CLKDIV_PERIOD 25

// 208 = 16 * 13, close to the 4MHz/16/13/8 tone of the real machine
`define ATOM_CAS_HALF_PERIOD 208

// Power-up stretch, 1024 cpu_clken pulses
`define ATOM_PWRUP_BITS 10

// Lock flag lives in bit 5 of this zero page byte
`define ATOM_LOCK_ADDR 16'h00E7

`endif

/* src/atom_system.sv */
// ====================
// Atom glue logic top level
// Clocking, memory map, PIA, read mux
// ====================

`timescale 1ns/100ps

module atom_system
   (
   input  logic                     clk25,
   input  logic                     reset,
   input  atom_io_pkg::speed_t      speed,
   input  logic                     sid_audio,
   // CPU side
   input  atom_bus_pkg::addr_t      cpu_address,
   input  atom_bus_pkg::byte_t      cpu_wdata,
   input  logic                     cpu_we,
   output atom_bus_pkg::byte_t      cpu_din,
   output logic                     cpu_clken,
   output logic                     sys_reset,
   output atom_bus_pkg::region_t    region,
   // Keyboard and cassette
   input  atom_io_pkg::key_col_t    key_col,
   input  logic                     shift_n,
   input  logic                     ctrl_n,
   input  logic                     rept_n,
   input  logic                     fs_n,
   input  logic                     cas_in,
   // Read data from devices outside this block
   input  atom_bus_pkg::byte_t      vid_dout,
   input  atom_bus_pkg::byte_t      via_dout,
   input  atom_bus_pkg::byte_t      spi_dout,
   input  atom_bus_pkg::byte_t      sid_dout,
   input  atom_bus_pkg::byte_t      ram_din,
   // External SRAM
   output atom_bus_pkg::ram_addr_t  ram_addr,
   output logic                     ram_we_b,
   output logic                     ram_oe_b,
   // Outputs
   output atom_bus_pkg::byte_t      port_a,
   output logic                     cas_out,
   output logic                     sound,
   output logic                     lock
   );
   import atom_bus_pkg::*;

   logic  wegate_b;
   byte_t pia_dout;
   byte_t rom_latch;

   // ====================
   // Shared captured bus
   // ====================
   cpu_bus_if bus (.cpu_clken(cpu_clken));

   assign region = bus.region;

   atom_clock_reset clock_reset0
      (
      .clk25     (clk25),
      .reset     (reset),
      .speed     (speed),
      .cpu_clken (cpu_clken),
      .wegate_b  (wegate_b),
      .sys_reset (sys_reset)
      );

   atom_memory_map memory_map0
      (
      .clk25       (clk25),
      .sys_reset   (sys_reset),
      .cpu_address (cpu_address),
      .cpu_wdata   (cpu_wdata),
      .cpu_we      (cpu_we),
      .wegate_b    (wegate_b),
      .bus         (bus.source),
      .rom_latch   (rom_latch),
      .ram_addr    (ram_addr),
      .ram_we_b    (ram_we_b),
      .ram_oe_b    (ram_oe_b),
      .lock        (lock)
      );

   // Port C low nibble fed the VDG colour set, not used here
   atom_pia pia0
      (
      .clk25     (clk25),
      .sys_reset (sys_reset),
      .bus       (bus.sink),
      .key_col   (key_col),
      .shift_n   (shift_n),
      .ctrl_n    (ctrl_n),
      .rept_n    (rept_n),
      .fs_n      (fs_n),
      .cas_in    (cas_in),
      .sid_audio (sid_audio),
      .pia_dout  (pia_dout),
      .port_a    (port_a),
      .pc_low    (),
      .cas_out   (cas_out),
      .sound     (sound)
      );

   atom_read_mux read_mux0
      (
      .bus       (bus.sink),
      .pia_dout  (pia_dout),
      .rom_latch (rom_latch),
      .vid_dout  (vid_dout),
      .via_dout  (via_dout),
      .spi_dout  (spi_dout),
      .sid_dout  (sid_dout),
      .ram_din   (ram_din),
      .cpu_din   (cpu_din)
      );

endmodule

/* src/cpu_bus_if.sv */
// ====================
// Captured CPU bus and region selects
// source and sink modports
// ====================

`timescale 1ns/100ps

interface cpu_bus_if
   (
   input logic cpu_clken
   );
   import atom_bus_pkg::*;

   // Registered CPU outputs
   addr_t   address;
   byte_t   wdata;
   logic    rnw;

   // Decoded from the captured address
   region_t region;

   // Capture and decode side
   modport source (input cpu_clken, output address, output wdata, output rnw,
                   output region);

   // Devices and read mux
   modport sink (input cpu_clken, input address, input wdata, input rnw,
                 input region);

endinterface

/* verification/atom_system_checker.sv */
// ====================
// Bound assertions on the Atom glue
// SRAM write strobe, clock enable, read mux
// ====================

`timescale 1ns/100ps

module atom_system_checker
   (
   input logic                  clk25,
   input logic                  reset,
   input logic                  cpu_clken,
   input logic                  ram_we_b,
   input logic                  ram_oe_b,
   input atom_bus_pkg::region_t region,
   input atom_bus_pkg::byte_t   cpu_din,
   input atom_bus_pkg::byte_t   ram_din
   );
   import atom_bus_pkg::*;

   // Sticky flags, one per assertion
   logic we_fail     = 1'b0;
   logic clken_fail  = 1'b0;
   logic read_fail   = 1'b0;
   logic failed;

   assign failed = we_fail || clken_fail || read_fail;

   // ram_oe_b is the inverse of the captured rnw
   we_strobe_check: assert property (@(posedge clk25) disable iff (reset)
      !ram_we_b |-> (ram_oe_b && !region[REG_ROM]))
   else
   begin
      we_fail = 1'b1;
      $error("ram_we_b low during a read or a ROM access");
   end

   // Single cycle enable at every speed
   clken_width_check: assert property (@(posedge clk25) disable iff (reset)
      cpu_clken |=> !cpu_clken)
   else
   begin
      clken_fail = 1'b1;
      $error("cpu_clken high for two cycles");
   end

   // No region selected means SRAM data
   ram_read_check: assert property (@(posedge clk25) disable iff (reset)
      (region == '0) |-> (cpu_din == ram_din))
   else
   begin
      read_fail = 1'b1;
      $error("cpu_din differs from ram_din with no region selected");
   end

endmodule

bind atom_system atom_system_checker checker0
   (
   .clk25     (clk25),
   .reset     (reset),
   .cpu_clken (cpu_clken),
   .ram_we_b  (ram_we_b),
   .ram_oe_b  (ram_oe_b),
   .region    (region),
   .cpu_din   (cpu_din),
   .ram_din   (ram_din)
   );

/* verification/atom_system_tb.sv */
// ====================
// Testbench for the Atom glue logic
// Clock, reset, access table, reference model,
// typed compare tasks and the run loop
// ====================

`timescale 1ns/100ps

module atom_system_tb;
   import atom_bus_pkg::*;
   import atom_io_pkg::*;

   localparam int MAX_ENTRIES   = 32;
   localparam int CLKEN_TIMEOUT = 64;
   localparam int RESET_TIMEOUT = 20000;

   // DUT inputs
   logic      clk25;
   logic      reset;
   speed_t    speed;
   logic      sid_audio;
   addr_t     cpu_address;
   byte_t     cpu_wdata;
   logic      cpu_we;
   key_col_t  key_col;
   logic      shift_n;
   logic      ctrl_n;
   logic      rept_n;
   logic      fs_n;
   logic      cas_in;
   byte_t     vid_dout;
   byte_t     via_dout;
   byte_t     spi_dout;
   byte_t     sid_dout;
   byte_t     ram_din;

   // DUT outputs
   byte_t     cpu_din;
   logic      cpu_clken;
   logic      sys_reset;
   region_t   region;
   ram_addr_t ram_addr;
   logic      ram_we_b;
   logic      ram_oe_b;
   byte_t     port_a;
   logic      cas_out;
   logic      sound;
   logic      lock;

   // ====================
   // Access table
   // ====================
   speed_t tbl_speed [MAX_ENTRIES];
   addr_t  tbl_addr  [MAX_ENTRIES];
   byte_t  tbl_wdata [MAX_ENTRIES];
   logic   tbl_write [MAX_ENTRIES];
   byte_t  tbl_exp   [MAX_ENTRIES];
   byte_t  tbl_mask  [MAX_ENTRIES];
   int     num_entries;

   // Reference model of the written state
   byte_t       model_port_a;
   pia_pc_low_t model_pc_low;
   byte_t       model_latch;
   logic        model_lock;

   // Set when ram_we_b is seen low in the access window
   logic        we_low_seen;

   always #2 clk25 = !clk25;

   atom_system dut0
      (
      .clk25       (clk25),
      .reset       (reset),
      .speed       (speed),
      .sid_audio   (sid_audio),
      .cpu_address (cpu_address),
      .cpu_wdata   (cpu_wdata),
      .cpu_we      (cpu_we),
      .cpu_din     (cpu_din),
      .cpu_clken   (cpu_clken),
      .sys_reset   (sys_reset),
      .region      (region),
      .key_col     (key_col),
      .shift_n     (shift_n),
      .ctrl_n      (ctrl_n),
      .rept_n      (rept_n),
      .fs_n        (fs_n),
      .cas_in      (cas_in),
      .vid_dout    (vid_dout),
      .via_dout    (via_dout),
      .spi_dout    (spi_dout),
      .sid_dout    (sid_dout),
      .ram_din     (ram_din),
      .ram_addr    (ram_addr),
      .ram_we_b    (ram_we_b),
      .ram_oe_b    (ram_oe_b),
      .port_a      (port_a),
      .cas_out     (cas_out),
      .sound       (sound),
      .lock        (lock)
      );

   // ====================
   // Failure and compare tasks
   // ====================
   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic compare_byte(input string name, input byte_t actual, input byte_t expected);
      if (actual !== expected)
         fail_run($sformatf("FAILED at %0t: %s is %h, expected %h",
                            $time, name, actual, expected));
   endtask

   task automatic compare_ram_addr(input string name, input ram_addr_t actual,
                                   input ram_addr_t expected);
      if (actual !== expected)
         fail_run($sformatf("FAILED at %0t: %s is %h, expected %h",
                            $time, name, actual, expected));
   endtask

   task automatic compare_region(input string name, input region_t actual,
                                 input region_t expected);
      if (actual !== expected)
         fail_run($sformatf("FAILED at %0t: %s is %b, expected %b",
                            $time, name, actual, expected));
   endtask

   task automatic compare_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected)
         fail_run($sformatf("FAILED at %0t: %s is %b, expected %b",
                            $time, name, actual, expected));
   endtask

   task automatic compare_count(input string name, input int actual, input int expected);
      if (actual != expected)
         fail_run($sformatf("FAILED at %0t: %s is %0d, expected %0d",
                            $time, name, actual, expected));
   endtask

   // Banked window A000-AFFF, everything else flat
   function automatic ram_addr_t expected_ram_addr(input addr_t address);
      if (address[15:12] == 4'hA)
         return {3'b010, model_latch[2:0], address[11:0]};
      else
         return {2'b00, address};
   endfunction

   // Atom memory map windows, one select bit each
   function automatic region_t expected_region(input addr_t address);
      region_t sel;
      sel = '0;
      if (address >= 16'hC000)
         sel[REG_ROM] = 1'b1;
      if ((address >= 16'hB000) && (address <= 16'hB00F))
         sel[REG_PIA] = 1'b1;
      if ((address >= 16'hB400) && (address <= 16'hB40F))
         sel[REG_PL8] = 1'b1;
      if ((address >= 16'hB800) && (address <= 16'hB80F))
         sel[REG_VIA] = 1'b1;
      if ((address >= 16'hBC00) && (address <= 16'hBC0F))
         sel[REG_SPI] = 1'b1;
      if ((address >= 16'hBD00) && (address <= 16'hBDFF))
         sel[REG_SID] = 1'b1;
      if ((address >= 16'h8000) && (address <= 16'h8FFF))
         sel[REG_VID] = 1'b1;
      if (address == 16'hBFFF)
         sel[REG_LATCH] = 1'b1;
      return sel;
   endfunction

   // ====================
   // Bus sequencing
   // ====================
   // Samples at the falling edge, away from register updates
   task automatic wait_clken();
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && (cycles < CLKEN_TIMEOUT))
      begin
         @(negedge clk25);
         if (!ram_we_b)
            we_low_seen = 1'b1;
         seen   = cpu_clken;
         cycles = cycles + 1;
      end
      if (!seen)
         fail_run("Timed out waiting for a cpu_clken pulse");
   endtask

   task automatic count_pulses(input speed_t sel, input int expected);
      int pulses;
      @(posedge clk25);
      speed <= sel;
      wait_clken();
      pulses = 0;
      // 100 cycles is exactly four divider frames
      repeat (100)
      begin
         @(negedge clk25);
         if (cpu_clken)
            pulses = pulses + 1;
      end
      compare_count($sformatf("cpu_clken pulses at speed %0d", sel), pulses, expected);
   endtask

   task automatic add_entry(input speed_t sel, input addr_t address, input byte_t wdata,
                            input logic write, input byte_t expected, input byte_t mask);
      if (num_entries >= MAX_ENTRIES)
         fail_run("Access table overflow");
      tbl_speed[num_entries] = sel;
      tbl_addr[num_entries]  = address;
      tbl_wdata[num_entries] = wdata;
      tbl_write[num_entries] = write;
      tbl_exp[num_entries]   = expected;
      tbl_mask[num_entries]  = mask;
      num_entries = num_entries + 1;
   endtask

   // Expected values depend on the random inputs, so built after seeding
   task automatic fill_table();
      byte_t port_b_val;
      byte_t port_c_top;
      port_b_val = {shift_n, ctrl_n, key_col};
      port_c_top = {fs_n, rept_n, cas_in, 5'b0};
      num_entries = 0;
      // Plain RAM, then PIA ports
      add_entry(SPEED_8MHZ, 16'h0400, 8'h00, 1'b0, ram_din, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hB000, 8'h5A, 1'b1, 8'h5A, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hB000, 8'h00, 1'b0, 8'h5A, 8'hFF);
      add_entry(SPEED_4MHZ, 16'hB001, 8'h00, 1'b0, port_b_val, 8'hFF);
      // Port C bit 4 is the free running tone
      add_entry(SPEED_8MHZ, 16'hB002, 8'hF5, 1'b1, port_c_top | 8'h05, 8'hEF);
      // Bit set and reset on register 3
      add_entry(SPEED_8MHZ, 16'hB003, 8'h03, 1'b1, 8'h00, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hB003, 8'h04, 1'b1, 8'h00, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hB003, 8'h82, 1'b1, 8'h00, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hB003, 8'h00, 1'b1, 8'h00, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hB002, 8'h00, 1'b0, port_c_top | 8'h02, 8'hEF);
      add_entry(SPEED_8MHZ, 16'hB002, 8'h08, 1'b1, port_c_top | 8'h08, 8'hEF);
      // ROM bank latch and banked window
      add_entry(SPEED_8MHZ, 16'hBFFF, 8'h05, 1'b1, 8'h05, 8'hFF);
      add_entry(SPEED_2MHZ, 16'hA123, 8'h00, 1'b0, ram_din, 8'hFF);
      // One read per device region
      add_entry(SPEED_8MHZ, 16'h8123, 8'h00, 1'b0, vid_dout, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hB803, 8'h00, 1'b0, via_dout, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hBC01, 8'h00, 1'b0, spi_dout, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hBD1F, 8'h00, 1'b0, sid_dout, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hB407, 8'h00, 1'b0, 8'h00, 8'hFF);
      add_entry(SPEED_1MHZ, 16'hF000, 8'h00, 1'b0, ram_din, 8'hFF);
      // Write protect on ROM, RAM write strobe
      add_entry(SPEED_8MHZ, 16'hE000, 8'h77, 1'b1, ram_din, 8'hFF);
      add_entry(SPEED_8MHZ, 16'h1234, 8'h99, 1'b1, ram_din, 8'hFF);
      // Lock flag snoop
      add_entry(SPEED_8MHZ, 16'h00E7, 8'h20, 1'b1, ram_din, 8'hFF);
      add_entry(SPEED_8MHZ, 16'h00E7, 8'hDF, 1'b1, ram_din, 8'hFF);
      add_entry(SPEED_4MHZ, 16'h00E7, 8'hFF, 1'b1, ram_din, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hBFFF, 8'h02, 1'b1, 8'h02, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hAFFF, 8'h00, 1'b0, ram_din, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hBFFF, 8'h00, 1'b0, 8'h02, 8'hFF);
      add_entry(SPEED_8MHZ, 16'hB000, 8'hC3, 1'b1, 8'hC3, 8'hFF);
   endtask

   task automatic update_model(input int i);
      addr_t address;
      byte_t wdata;
      address = tbl_addr[i];
      wdata   = tbl_wdata[i];
      if (tbl_write[i])
      begin
         if (address[15:4] == 12'hB00)
         begin
            case (address[1:0])
               2'd0: model_port_a = wdata;
               2'd2: model_pc_low = wdata[3:0];
               2'd3:
                  if (!wdata[7])
                     model_pc_low[wdata[2:1]] = wdata[0];
               default: ;
            endcase
         end
         if (address == 16'hBFFF)
            model_latch = wdata;
         if (address == 16'h00E7)
            model_lock = wdata[5];
      end
   endtask

   // Held across two pulses, effect lands at the second one
   task automatic apply_entry(input int i);
      logic is_rom;
      is_rom = (tbl_addr[i][15:14] == 2'b11);
      @(posedge clk25);
      speed       <= tbl_speed[i];
      cpu_address <= tbl_addr[i];
      cpu_wdata   <= tbl_wdata[i];
      cpu_we      <= tbl_write[i];
      wait_clken();
      we_low_seen = 1'b0;
      wait_clken();
      @(posedge clk25);
      @(negedge clk25);
      update_model(i);
      compare_byte("cpu_din", cpu_din & tbl_mask[i], tbl_exp[i] & tbl_mask[i]);
      compare_byte("port_a", port_a, model_port_a);
      compare_region("region", region, expected_region(tbl_addr[i]));
      compare_ram_addr("ram_addr", ram_addr, expected_ram_addr(tbl_addr[i]));
      // Output enable is active low on reads
      compare_bit("ram_oe_b", ram_oe_b, tbl_write[i]);
      compare_bit("ram_we_b low in window", we_low_seen, tbl_write[i] && !is_rom);
      compare_bit("lock", lock, model_lock);
      compare_bit("sound", sound, model_pc_low[2] ^ sid_audio);
      // Tone only reaches cas_out with pc0 and pc1 both set
      if (!(model_pc_low[0] && model_pc_low[1]))
         compare_bit("cas_out", cas_out, model_pc_low[0]);
   endtask

   // Assertion failures in the bound checker end the run
   always @(negedge clk25)
   begin
      if (dut0.checker0.failed)
         fail_run("An assertion in the bound checker failed");
   end

   // ====================
   // Run
   // ====================
   initial
   begin
      int cycles;
      clk25       = 1'b0;
      reset       = 1'b1;
      speed       = SPEED_8MHZ;
      cpu_address = '0;
      cpu_wdata   = '0;
      cpu_we      = 1'b0;
      we_low_seen = 1'b0;
      void'($urandom(32'h57589b00));
      sid_audio   = 1'($urandom);
      key_col     = key_col_t'($urandom);
      shift_n     = 1'($urandom);
      ctrl_n      = 1'($urandom);
      rept_n      = 1'($urandom);
      fs_n        = 1'($urandom);
      cas_in      = 1'($urandom);
      vid_dout    = byte_t'($urandom);
      via_dout    = byte_t'($urandom);
      spi_dout    = byte_t'($urandom);
      sid_dout    = byte_t'($urandom);
      ram_din     = byte_t'($urandom);
      model_port_a = '0;
      model_pc_low = '0;
      model_latch  = '0;
      model_lock   = 1'b0;
      fill_table();

      repeat (4) @(posedge clk25);
      reset <= 1'b0;

      // Power-up stretch runs on cpu_clken pulses
      cycles = 0;
      while (sys_reset && (cycles < RESET_TIMEOUT))
      begin
         @(negedge clk25);
         cycles = cycles + 1;
      end
      if (sys_reset)
         fail_run("sys_reset was never released after power-up");

      count_pulses(SPEED_1MHZ, 4);
      count_pulses(SPEED_2MHZ, 8);
      count_pulses(SPEED_4MHZ, 16);
      count_pulses(SPEED_8MHZ, 32);

      for (int i = 0; i < num_entries; i++)
         apply_entry(i);

      if (!dut0.checker0.failed)
      begin
         $display("All tests passed");
         $finish;
      end
      else
         fail_run("An assertion in the bound checker failed");
   end

endmodule
